//--- design/core_pkg.sv
package core_pkg;

	import rv_isa_pkg::*;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_sel_t;

	typedef enum logic [1:0] {
		CLS_ALU,
		CLS_MUL,
		CLS_DIV,
		CLS_NONE
	} op_class_t;

	typedef struct packed {
		op_class_t cls;
		alu_sel_t  alu_sel;
		funct3_t   funct3;
		reg_id_t   rs1;
		reg_id_t   rs2;
		reg_id_t   rd;
		logic      use_imm;
		word_t     imm;
	} dec_op_t;

	typedef struct packed {
		logic    valid;
		reg_id_t rd;
		word_t   data;
	} retire_t;

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_BUSY,
		HS_ACK
	} hs_state_t;

	localparam int DIV_STEPS = 32;
	localparam int DIV_CNT_W = $clog2(DIV_STEPS);

endpackage

//--- design/rv_alu.sv
module rv_alu import rv_isa_pkg::*, core_pkg::*; (
	input  word_t    a_i,
	input  word_t    b_i,
	input  alu_sel_t sel_i,
	output word_t    y_o
);

	logic [XLEN:0] minus;
	logic [XLEN:0] sh_ext;
	logic          lt;
	logic          lts;
	word_t         sh_in;
	word_t         sh_out;

	function automatic word_t rev(input word_t v);
		word_t r;
		for (int i = 0; i < XLEN; i++) begin
			r[i] = v[XLEN-1-i];
		end
		return r;
	endfunction

	// Shared subtractor, carry out gives unsigned less-than
	assign minus = {1'b1, ~b_i} + {1'b0, a_i} + 1'b1;
	assign lt    = minus[XLEN];
	assign lts   = (a_i[XLEN-1] ^ b_i[XLEN-1]) ? a_i[XLEN-1] : lt;

	// Left shift runs through the right shifter bit-reversed
	assign sh_in  = (sel_i == ALU_SLL) ? rev(a_i) : a_i;
	assign sh_ext = $signed({sel_i == ALU_SRA && a_i[XLEN-1], sh_in}) >>> b_i[4:0];
	assign sh_out = sh_ext[XLEN-1:0];

	always_comb begin
		case (sel_i)
			ALU_ADD:    y_o = a_i + b_i;
			ALU_SUB:    y_o = minus[XLEN-1:0];
			ALU_SLL:    y_o = rev(sh_out);
			ALU_SLT:    y_o = {{(XLEN-1){1'b0}}, lts};
			ALU_SLTU:   y_o = {{(XLEN-1){1'b0}}, lt};
			ALU_XOR:    y_o = a_i ^ b_i;
			ALU_SRL:    y_o = sh_out;
			ALU_SRA:    y_o = sh_out;
			ALU_OR:     y_o = a_i | b_i;
			ALU_AND:    y_o = a_i & b_i;
			ALU_PASS_B: y_o = b_i;
			default:    y_o = '0;
		endcase
	end

endmodule

//--- design/rv_core.sv
module rv_core import rv_isa_pkg::*, core_pkg::*; (
	input  logic    PH0IN,
	input  logic    rst_n,
	input  logic    instr_req_i,
	input  instr_t  instr_i,
	output logic    instr_ack_o,
	output retire_t retire_o
);

	dec_op_t issue;
	logic    issue_valid;
	reg_id_t rs1_id;
	reg_id_t rs2_id;
	word_t   rs1;
	word_t   rs2;

	rv_decode decode0 (
		.PH0IN          (PH0IN),
		.rst_n          (rst_n),
		.instr_req_i    (instr_req_i),
		.instr_i        (instr_i),
		.retire_valid_i (retire_o.valid),
		.instr_ack_o    (instr_ack_o),
		.issue_o        (issue),
		.issue_valid_o  (issue_valid)
	);

	rv_execute execute0 (
		.PH0IN         (PH0IN),
		.rst_n         (rst_n),
		.issue_i       (issue),
		.issue_valid_i (issue_valid),
		.rs1_i         (rs1),
		.rs2_i         (rs2),
		.rs1_id_o      (rs1_id),
		.rs2_id_o      (rs2_id),
		.retire_o      (retire_o)
	);

	rv_regfile regfile0 (
		.PH0IN    (PH0IN),
		.rs1_id_i (rs1_id),
		.rs2_id_i (rs2_id),
		.rs1_o    (rs1),
		.rs2_o    (rs2),
		.retire_i (retire_o)
	);

endmodule

//--- design/rv_decode.sv
module rv_decode import rv_isa_pkg::*, core_pkg::*; (
	input  logic    PH0IN,
	input  logic    rst_n,
	input  logic    instr_req_i,
	input  instr_t  instr_i,
	input  logic    retire_valid_i,
	output logic    instr_ack_o,
	output dec_op_t issue_o,
	output logic    issue_valid_o
);

	hs_state_t state;
	dec_op_t   dec;
	alu_sel_t  sel;
	opcode_t   opcode;
	funct3_t   funct3;
	funct7_t   funct7;
	word_t     imm_i;
	word_t     imm_u;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_u  = {instr_i[31:12], 12'h000};

	always_comb begin
		case (funct3)
			F3_ADD_SUB: sel = ALU_ADD;
			F3_SLL:     sel = ALU_SLL;
			F3_SLT:     sel = ALU_SLT;
			F3_SLTU:    sel = ALU_SLTU;
			F3_XOR:     sel = ALU_XOR;
			F3_SRL_SRA: sel = instr_i[30] ? ALU_SRA : ALU_SRL;
			F3_OR:      sel = ALU_OR;
			F3_AND:     sel = ALU_AND;
		endcase
	end

	always_comb begin
		dec.cls     = CLS_NONE;
		dec.alu_sel = sel;
		dec.funct3  = funct3;
		dec.rs1     = instr_i[19:15];
		dec.rs2     = instr_i[24:20];
		dec.rd      = instr_i[11:7];
		dec.use_imm = 1'b0;
		dec.imm     = imm_i;
		case (opcode)
			OP_ALUREG: begin
				if (funct7 == F7_MULDIV) begin
					dec.cls = funct3[2] ? CLS_DIV : CLS_MUL;
				end else begin
					dec.cls = CLS_ALU;
					// Bit 30 turns add into sub only on OP
					if (funct3 == F3_ADD_SUB && instr_i[30]) begin
						dec.alu_sel = ALU_SUB;
					end
				end
			end
			OP_ALUIMM: begin
				dec.cls     = CLS_ALU;
				dec.use_imm = 1'b1;
			end
			OP_LUI: begin
				dec.cls     = CLS_ALU;
				dec.alu_sel = ALU_PASS_B;
				dec.use_imm = 1'b1;
				dec.imm     = imm_u;
			end
			// Unsupported, retire without write
			default: dec.rd = '0;
		endcase
	end

	// Four-phase handshake
	always_ff @(posedge PH0IN) begin
		if (!rst_n) begin
			state         <= HS_IDLE;
			issue_valid_o <= 1'b0;
		end else begin
			issue_valid_o <= 1'b0;
			case (state)
				HS_IDLE: begin
					if (instr_req_i) begin
						issue_o       <= dec;
						issue_valid_o <= 1'b1;
						state         <= HS_BUSY;
					end
				end
				HS_BUSY: begin
					if (retire_valid_i) begin
						state <= HS_ACK;
					end
				end
				HS_ACK: begin
					if (!instr_req_i) begin
						state <= HS_IDLE;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	assign instr_ack_o = state == HS_ACK;

endmodule

//--- design/rv_execute.sv
module rv_execute import rv_isa_pkg::*, core_pkg::*; (
	input  logic    PH0IN,
	input  logic    rst_n,
	input  dec_op_t issue_i,
	input  logic    issue_valid_i,
	input  word_t   rs1_i,
	input  word_t   rs2_i,
	output reg_id_t rs1_id_o,
	output reg_id_t rs2_id_o,
	output retire_t retire_o
);

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_RUN,
		EX_WAIT
	} ex_state_t;

	ex_state_t state;
	dec_op_t   op_q;
	word_t     opb;
	word_t     alu_y;
	word_t     md_y;
	logic      md_start;
	logic      md_done;

	always_ff @(posedge PH0IN) begin
		if (issue_valid_i) begin
			op_q <= issue_i;
		end
	end

	assign rs1_id_o = op_q.rs1;
	assign rs2_id_o = op_q.rs2;
	assign opb      = op_q.use_imm ? op_q.imm : rs2_i;
	assign md_start = state == EX_RUN && (op_q.cls == CLS_MUL || op_q.cls == CLS_DIV);

	rv_alu alu0 (
		.a_i   (rs1_i),
		.b_i   (opb),
		.sel_i (op_q.alu_sel),
		.y_o   (alu_y)
	);

	rv_muldiv muldiv0 (
		.PH0IN    (PH0IN),
		.rst_n    (rst_n),
		.start_i  (md_start),
		.funct3_i (op_q.funct3),
		.a_i      (rs1_i),
		.b_i      (rs2_i),
		.y_o      (md_y),
		.done_o   (md_done)
	);

	always_ff @(posedge PH0IN) begin
		if (!rst_n) begin
			state          <= EX_IDLE;
			retire_o.valid <= 1'b0;
		end else begin
			retire_o.valid <= 1'b0;
			case (state)
				EX_IDLE: begin
					if (issue_valid_i) begin
						state <= EX_RUN;
					end
				end
				EX_RUN: begin
					// Single-cycle ops retire straight away
					if (md_start) begin
						state <= EX_WAIT;
					end else begin
						retire_o <= {1'b1, op_q.rd, alu_y};
						state    <= EX_IDLE;
					end
				end
				EX_WAIT: begin
					if (md_done) begin
						retire_o <= {1'b1, op_q.rd, md_y};
						state    <= EX_IDLE;
					end
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

endmodule

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_id_t;
	typedef logic [2:0]      funct3_t;
	typedef logic [6:0]      funct7_t;
	typedef logic [6:0]      opcode_t;
	typedef logic [31:0]     instr_t;

	// Major opcodes
	localparam opcode_t OP_ALUREG = 7'b0110011;
	localparam opcode_t OP_ALUIMM = 7'b0010011;
	localparam opcode_t OP_LUI    = 7'b0110111;

	// M extension marker on OP
	localparam funct7_t F7_MULDIV = 7'b0000001;

	// OP and OP-IMM sub-codes
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

endpackage

//--- design/rv_muldiv.sv
module rv_muldiv import rv_isa_pkg::*, core_pkg::*; (
	input  logic    PH0IN,
	input  logic    rst_n,
	input  logic    start_i,
	input  funct3_t funct3_i,
	input  word_t   a_i,
	input  word_t   b_i,
	output word_t   y_o,
	output logic    done_o
);

	typedef enum logic [1:0] {
		MD_IDLE,
		MD_DIV,
		MD_DONE
	} md_state_t;

	md_state_t            state;
	logic [DIV_CNT_W-1:0] cnt;
	logic                 m1s;
	logic                 m2s;
	logic                 signed_div;
	logic                 res_sign;
	logic                 fits;
	logic                 mul_neg_q;
	word_t                a_neg;
	word_t                b_neg;
	word_t                mul_a;
	word_t                mul_b;
	word_t                div_a;
	word_t                div_b;
	word_t                quot;
	word_t                div_out;
	logic [2*XLEN-1:0]    prod_q;
	logic [2*XLEN-1:0]    mul_res;
	logic [2*XLEN-1:0]    div_sh;
	logic [XLEN:0]        partial;

	assign a_neg = ~a_i + 1'b1;
	assign b_neg = ~b_i + 1'b1;

	// MUL, MULH and MULHSU treat rs1 as signed, MUL and MULH also rs2
	assign m1s   = funct3_i <= 3'd2 && a_i[XLEN-1];
	assign m2s   = funct3_i <= 3'd1 && b_i[XLEN-1];
	assign mul_a = m1s ? a_neg : a_i;
	assign mul_b = m2s ? b_neg : b_i;

	assign signed_div = funct3_i[2] && !funct3_i[0];
	assign res_sign   = signed_div && (a_i[XLEN-1] ^ b_i[XLEN-1]);
	assign div_a      = (signed_div && a_i[XLEN-1]) ? a_neg : a_i;
	assign div_b      = (signed_div && b_i[XLEN-1]) ? b_neg : b_i;

	// Remainder shifted left by one plus next dividend bit
	assign partial = div_sh[2*XLEN-1:XLEN-1];
	assign fits    = partial >= {1'b0, div_b};

	always_ff @(posedge PH0IN) begin
		if (start_i && !funct3_i[2]) begin
			prod_q    <= mul_a * mul_b;
			mul_neg_q <= m1s ^ m2s;
		end
		if (start_i && funct3_i[2]) begin
			div_sh <= {{XLEN{1'b0}}, div_a};
			quot   <= '0;
		end else if (state == MD_DIV) begin
			quot <= {quot[XLEN-2:0], fits};
			if (fits) begin
				div_sh <= {partial[XLEN-1:0] - div_b, div_sh[XLEN-2:0], 1'b0};
			end else begin
				div_sh <= {div_sh[2*XLEN-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge PH0IN) begin
		if (!rst_n) begin
			state <= MD_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				MD_IDLE: begin
					if (start_i) begin
						state <= funct3_i[2] ? MD_DIV : MD_DONE;
						cnt   <= '0;
					end
				end
				MD_DIV: begin
					cnt <= cnt + 1'b1;
					if (cnt == DIV_CNT_W'(DIV_STEPS - 1)) begin
						state <= MD_DONE;
					end
				end
				default: state <= MD_IDLE;
			endcase
		end
	end

	assign mul_res = mul_neg_q ? ~prod_q + 1'b1 : prod_q;
	assign div_out = funct3_i[1] ? div_sh[2*XLEN-1:XLEN] : quot;

	// Sign fix-up, remainder follows the dividend
	always_comb begin
		case (funct3_i)
			3'b000:  y_o = mul_res[XLEN-1:0];
			3'b001:  y_o = mul_res[2*XLEN-1:XLEN];
			3'b010:  y_o = mul_res[2*XLEN-1:XLEN];
			3'b011:  y_o = mul_res[2*XLEN-1:XLEN];
			3'b100:  y_o = res_sign ? ~div_out + 1'b1 : div_out;
			3'b110:  y_o = a_i[XLEN-1] ? ~div_out + 1'b1 : div_out;
			default: y_o = div_out;
		endcase
	end

	assign done_o = state == MD_DONE;

endmodule

//--- design/rv_regfile.sv
module rv_regfile import rv_isa_pkg::*, core_pkg::*; (
	input  logic    PH0IN,
	input  reg_id_t rs1_id_i,
	input  reg_id_t rs2_id_i,
	output word_t   rs1_o,
	output word_t   rs2_o,
	input  retire_t retire_i
);

	word_t regs [0:31];

	always_ff @(posedge PH0IN) begin
		if (retire_i.valid && retire_i.rd != '0) begin
			regs[retire_i.rd] <= retire_i.data;
		end
	end

	// x0 reads as zero, never stored
	assign rs1_o = (rs1_id_i == '0) ? '0 : regs[rs1_id_i];
	assign rs2_o = (rs2_id_i == '0) ? '0 : regs[rs2_id_i];

endmodule

//--- test/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: instruction, retire rd, retire data, data checked,
// extra cycles that req stays high after ack
localparam int NUM_VECS = 42;

localparam vec_t VECS [NUM_VECS] = '{
	// Operand setup
	'{u_type(20'h12345, 5'd1), 5'd1, 32'h1234_5000, 1'b1, 2'd0},
	'{i_type(12'h678, F3_ADD_SUB, 5'd1, 5'd1), 5'd1, 32'h1234_5678, 1'b1, 2'd0},
	'{i_type(12'hffb, F3_ADD_SUB, 5'd2, 5'd0), 5'd2, 32'hffff_fffb, 1'b1, 2'd0},
	'{i_type(12'h007, F3_ADD_SUB, 5'd3, 5'd0), 5'd3, 32'h0000_0007, 1'b1, 2'd0},
	'{u_type(20'h80000, 5'd4), 5'd4, 32'h8000_0000, 1'b1, 2'd0},
	'{i_type(12'hfff, F3_ADD_SUB, 5'd5, 5'd0), 5'd5, 32'hffff_ffff, 1'b1, 2'd0},
	'{i_type(12'hf9c, F3_ADD_SUB, 5'd15, 5'd0), 5'd15, 32'hffff_ff9c, 1'b1, 2'd0},
	// Register and immediate ALU ops
	'{r_type(7'h00, F3_ADD_SUB, 5'd6, 5'd1, 5'd3), 5'd6, 32'h1234_567f, 1'b1, 2'd3},
	'{r_type(7'h20, F3_ADD_SUB, 5'd7, 5'd3, 5'd2), 5'd7, 32'h0000_000c, 1'b1, 2'd0},
	'{r_type(7'h00, F3_SLL, 5'd8, 5'd1, 5'd3), 5'd8, 32'h1a2b_3c00, 1'b1, 2'd0},
	'{r_type(7'h00, F3_SRL_SRA, 5'd8, 5'd2, 5'd3), 5'd8, 32'h01ff_ffff, 1'b1, 2'd0},
	'{r_type(7'h20, F3_SRL_SRA, 5'd8, 5'd2, 5'd3), 5'd8, 32'hffff_ffff, 1'b1, 2'd0},
	'{i_type(12'h404, F3_SRL_SRA, 5'd9, 5'd4), 5'd9, 32'hf800_0000, 1'b1, 2'd0},
	'{i_type(12'h01c, F3_SLL, 5'd9, 5'd3), 5'd9, 32'h7000_0000, 1'b1, 2'd0},
	'{r_type(7'h00, F3_SLT, 5'd10, 5'd2, 5'd3), 5'd10, 32'h0000_0001, 1'b1, 2'd0},
	'{r_type(7'h00, F3_SLTU, 5'd10, 5'd2, 5'd3), 5'd10, 32'h0000_0000, 1'b1, 2'd0},
	'{r_type(7'h00, F3_SLT, 5'd10, 5'd3, 5'd4), 5'd10, 32'h0000_0000, 1'b1, 2'd0},
	'{i_type(12'hfff, F3_SLTU, 5'd10, 5'd3), 5'd10, 32'h0000_0001, 1'b1, 2'd0},
	'{r_type(7'h00, F3_XOR, 5'd11, 5'd1, 5'd5), 5'd11, 32'hedcb_a987, 1'b1, 2'd0},
	'{r_type(7'h00, F3_OR, 5'd11, 5'd1, 5'd4), 5'd11, 32'h9234_5678, 1'b1, 2'd0},
	'{i_type(12'h0f0, F3_AND, 5'd11, 5'd1), 5'd11, 32'h0000_0070, 1'b1, 2'd0},
	// Write to x0 is dropped
	'{r_type(7'h00, F3_ADD_SUB, 5'd0, 5'd1, 5'd3), 5'd0, 32'h1234_567f, 1'b1, 2'd0},
	'{r_type(7'h00, F3_ADD_SUB, 5'd12, 5'd0, 5'd1), 5'd12, 32'h1234_5678, 1'b1, 2'd0},
	// MUL 0, MULH 1, MULHSU 2, MULHU 3
	'{r_type(7'h01, 3'd0, 5'd13, 5'd1, 5'd3), 5'd13, 32'h7f6e_5d48, 1'b1, 2'd2},
	'{r_type(7'h01, 3'd1, 5'd13, 5'd3, 5'd2), 5'd13, 32'hffff_ffff, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd3, 5'd13, 5'd2, 5'd3), 5'd13, 32'h0000_0006, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd2, 5'd13, 5'd3, 5'd2), 5'd13, 32'h0000_0006, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd2, 5'd13, 5'd2, 5'd5), 5'd13, 32'hffff_fffb, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd1, 5'd13, 5'd4, 5'd4), 5'd13, 32'h4000_0000, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd3, 5'd13, 5'd5, 5'd5), 5'd13, 32'hffff_fffe, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd0, 5'd13, 5'd4, 5'd5), 5'd13, 32'h8000_0000, 1'b1, 2'd0},
	// DIV 4, DIVU 5, REM 6, REMU 7
	'{r_type(7'h01, 3'd4, 5'd14, 5'd15, 5'd3), 5'd14, 32'hffff_fff2, 1'b1, 2'd3},
	'{r_type(7'h01, 3'd6, 5'd14, 5'd15, 5'd3), 5'd14, 32'hffff_fffe, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd4, 5'd14, 5'd15, 5'd2), 5'd14, 32'h0000_0014, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd6, 5'd14, 5'd3, 5'd2), 5'd14, 32'h0000_0002, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd5, 5'd14, 5'd15, 5'd3), 5'd14, 32'h2492_4916, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd7, 5'd14, 5'd15, 5'd3), 5'd14, 32'h0000_0002, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd4, 5'd14, 5'd4, 5'd5), 5'd14, 32'h8000_0000, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd5, 5'd14, 5'd1, 5'd0), 5'd14, 32'hffff_ffff, 1'b1, 2'd0},
	'{r_type(7'h01, 3'd7, 5'd14, 5'd1, 5'd0), 5'd14, 32'h1234_5678, 1'b1, 2'd0},
	// SW x2, 1(x1) is not supported
	// Its low offset bits sit in the rd field and name x1
	'{32'h0020_a0a3, 5'd0, 32'h0000_0000, 1'b0, 2'd1},
	'{r_type(7'h00, F3_ADD_SUB, 5'd12, 5'd1, 5'd2), 5'd12, 32'h1234_5673, 1'b1, 2'd0}
};

`endif

//--- test/tb_rv_core.sv
module tb_rv_core import rv_isa_pkg::*, core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 8;
	localparam int ROW_CYCLES   = 45;

	typedef struct packed {
		instr_t     instr;
		reg_id_t    rd;
		word_t      data;
		logic       check_data;
		logic [1:0] hold;
	} vec_t;

	logic    PH0IN;
	logic    rst_n;
	logic    instr_req;
	instr_t  instr;
	logic    instr_ack;
	retire_t retire;
	retire_t last_retire;
	int      retire_count = 0;

	function automatic instr_t r_type(input funct7_t f7, input funct3_t f3, input reg_id_t rd,
		input reg_id_t rs1, input reg_id_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic instr_t i_type(input logic [11:0] imm, input funct3_t f3,
		input reg_id_t rd, input reg_id_t rs1);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic instr_t u_type(input logic [19:0] imm, input reg_id_t rd);
		return {imm, rd, 7'b0110111};
	endfunction

	`include "tb_vectors.svh"

	rv_core dut0 (
		.PH0IN       (PH0IN),
		.rst_n       (rst_n),
		.instr_req_i (instr_req),
		.instr_i     (instr),
		.instr_ack_o (instr_ack),
		.retire_o    (retire)
	);

	initial begin
		PH0IN = 1'b0;
		forever #(CLK_PERIOD / 2) PH0IN = ~PH0IN;
	end

	// Retire pulses counted mid-cycle
	always @(negedge PH0IN) begin
		if (rst_n && retire.valid) begin
			retire_count <= retire_count + 1;
			last_retire  <= retire;
		end
	end

	task automatic fail_run();
		$display("Testbench failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			fail_run();
		end
	endtask

	// One four-phase exchange per table row
	task automatic run_row(input int idx);
		vec_t v;
		int   count_before;
		v = VECS[idx];
		count_before = retire_count;
		instr     = v.instr;
		instr_req = 1'b1;
		@(negedge PH0IN);
		while (!instr_ack) begin
			@(negedge PH0IN);
		end
		check_value($sformatf("retire count (row %0d)", idx), retire_count - count_before, 1);
		check_value($sformatf("retire_o.rd (row %0d)", idx), last_retire.rd, v.rd);
		if (v.check_data) begin
			check_value($sformatf("retire_o.data (row %0d)", idx), last_retire.data, v.data);
		end
		// Req held past ack
		repeat (v.hold) begin
			@(negedge PH0IN);
			if (!instr_ack) begin
				$display("Ack dropped while req was still held high in row %0d", idx);
				fail_run();
			end
		end
		instr_req = 1'b0;
		@(negedge PH0IN);
		if (instr_ack) begin
			$display("Ack stayed high after req fell in row %0d", idx);
			fail_run();
		end
		// Pulses sampled through the last held cycle are counted by now
		check_value($sformatf("retire count after hold (row %0d)", idx),
			retire_count - count_before, 1);
	endtask

	initial begin
		rst_n     = 1'b0;
		instr_req = 1'b0;
		instr     = '0;
		repeat (RESET_CYCLES) @(posedge PH0IN);
		@(negedge PH0IN);
		check_value("instr_ack_o after reset", instr_ack, 0);
		check_value("retire_o.valid after reset", retire.valid, 0);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_VECS; i++) begin
			run_row(i);
		end
		$display("Testbench passed");
		$finish;
	end

	initial begin
		#((NUM_VECS * ROW_CYCLES + RESET_CYCLES) * CLK_PERIOD);
		$display("Timeout, the core stopped answering the instruction handshake");
		fail_run();
	end

endmodule

//--- verilog.f
+incdir+test
design/rv_isa_pkg.sv
design/core_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_muldiv.sv
design/rv_execute.sv
design/rv_core.sv
test/tb_rv_core.sv
